// File: hw/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Byte address width
`define FETCH_XLEN 32

// Icache line size in bytes
`define FETCH_LINE_BYTES 64

// BTB entries as a power of two
`define FETCH_BTB_ENTRIES 16

// Lines held by the instruction buffer
// Power of two of at least 2
`define FETCH_IBUFF_DEPTH 4

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: hw/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] addr_t;           // Byte address
    typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;   // Byte 0 in the low bits
    typedef logic [31:0] insn_t;                      // One instruction word

    // Redirect from one source
    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // Back end resteer with one strobe for all three sources
    typedef struct packed {
        logic      strobe;
        redirect_t rob;      // Highest priority
        redirect_t dec;
        redirect_t ras;      // Lowest of the three
    } resteer_t;

    // One branch resolution
    typedef struct packed {
        logic  strobe;
        addr_t pc;           // Address of the branch
        addr_t target;
        logic  taken;
    } btb_update_t;

    // One icache line fill
    typedef struct packed {
        logic  strobe;
        addr_t addr;         // Low bits give the start offset
        line_t line;
    } fill_t;

endpackage

// File: hw/fetch_pc.sv
`include "fetch_cfg.svh"

module fetch_pc (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 ibuff_full,
    input  fetch_pkg::resteer_t  resteer,
    input  fetch_pkg::redirect_t pred,
    output fetch_pkg::addr_t     pc,
    output logic                 req
);

    // Offset bits within a line
    localparam fetch_pkg::addr_t LINE_MASK = fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);
    localparam fetch_pkg::addr_t LINE_STEP = fetch_pkg::addr_t'(`FETCH_LINE_BYTES);

    logic             live_q;    // Low in the first cycle out of reset
    fetch_pkg::addr_t seq_pc;    // Next line base
    fetch_pkg::addr_t pc_next;

    // Back-pressure point for the whole stage
    assign req = live_q && !stall && !ibuff_full;

    assign seq_pc = (pc & ~LINE_MASK) + LINE_STEP;

    // Priority runs rob, dec, ras, prediction, sequential
    always_comb begin
        pc_next = seq_pc;
        if (resteer.strobe && resteer.rob.taken) begin
            pc_next = resteer.rob.target;
        end else if (resteer.strobe && resteer.dec.taken) begin
            pc_next = resteer.dec.target;
        end else if (resteer.strobe && resteer.ras.taken) begin
            pc_next = resteer.ras.target;
        end else if (pred.taken) begin
            pc_next = pred.target;     // Strobe with nothing taken lands here too
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live_q <= 1'b0;
            pc     <= fetch_pkg::addr_t'(`FETCH_RESET_PC);
        end else begin
            live_q <= 1'b1;
            if (req) begin
                pc <= pc_next;             // Hold otherwise even on resteer
            end
        end
    end

endmodule

// File: hw/btb_predictor.sv
`include "fetch_cfg.svh"

module btb_predictor (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::addr_t       lookup_pc,
    input  fetch_pkg::btb_update_t update,
    output fetch_pkg::redirect_t   pred
);

    localparam int ENTRIES = `FETCH_BTB_ENTRIES;
    localparam int OFF_W   = $clog2(`FETCH_LINE_BYTES);
    localparam int IDX_W   = $clog2(ENTRIES);
    localparam int TAG_W   = `FETCH_XLEN - OFF_W - IDX_W;

    // Entry state
    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_q    [ENTRIES];
    fetch_pkg::addr_t   target_q [ENTRIES];
    logic [1:0]         ctr_q    [ENTRIES];   // 2-bit saturating counter

    // Lookup side
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             rd_hit;

    // Update side
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_hit;
    logic [1:0]       ctr_next;

    // Index sits just above the line offset
    assign rd_idx = lookup_pc[OFF_W +: IDX_W];
    assign rd_tag = lookup_pc[OFF_W + IDX_W +: TAG_W];
    assign wr_idx = update.pc[OFF_W +: IDX_W];
    assign wr_tag = update.pc[OFF_W + IDX_W +: TAG_W];

    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    // Taken only on a strong or weak taken counter
    assign pred.taken  = rd_hit && ctr_q[rd_idx][1];
    assign pred.target = target_q[rd_idx];

    always_comb begin
        ctr_next = ctr_q[wr_idx];
        if (!wr_hit) begin
            ctr_next = 2'b01;                      // New branch starts weakly not taken
        end else if (update.taken) begin
            if (ctr_q[wr_idx] != 2'b11) begin
                ctr_next = ctr_q[wr_idx] + 2'b01;
            end
        end else begin
            if (ctr_q[wr_idx] != 2'b00) begin
                ctr_next = ctr_q[wr_idx] - 2'b01;
            end
        end
    end

    // Valid bits only
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.strobe) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag, target and counter storage
    always_ff @(posedge clk) begin
        if (update.strobe) begin
            ctr_q[wr_idx] <= ctr_next;
            if (!wr_hit) begin
                tag_q[wr_idx] <= wr_tag;           // Install or replace
            end
            if (!wr_hit || update.taken) begin
                target_q[wr_idx] <= update.target;
            end
        end
    end

endmodule

// File: hw/ibuff.sv
`include "fetch_cfg.svh"

module ibuff (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             stall,
    input  fetch_pkg::fill_t fill,
    output fetch_pkg::insn_t insn,
    output logic             insn_valid,
    output logic             full
);

    localparam int DEPTH  = `FETCH_IBUFF_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int OFF_W  = $clog2(`FETCH_LINE_BYTES);
    localparam int LINE_W = `FETCH_LINE_BYTES * 8;

    // Line storage with the start offset of each line
    fetch_pkg::line_t line_q  [DEPTH];
    logic [OFF_W-1:0] start_q [DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W:0]   count_q;
    logic [OFF_W-1:0] rd_off_q;      // Byte offset into the head line
    logic [OFF_W:0]   rd_off_inc;    // Carry out means line used up

    logic             push;
    logic             pop;
    logic             advance;
    logic             new_head;      // Fill becomes the head line
    logic [OFF_W+3:0] shamt;         // Rotate amount in bits
    fetch_pkg::line_t rotated;

    assign insn_valid = (count_q != '0);
    assign full       = (count_q == (PTR_W+1)'(DEPTH));

    assign advance    = insn_valid && !stall;
    assign rd_off_inc = {1'b0, rd_off_q} + (OFF_W+1)'(4);
    assign pop        = advance && rd_off_inc[OFF_W];
    assign push       = fill.strobe && !full && !flush;   // Fill lost when full
    assign head_nxt   = head_q + PTR_W'(1);
    assign new_head   = (count_q == '0) || (pop && count_q == (PTR_W+1)'(1));

    // Rotate right so the byte at rd_off lands at bit 0
    assign shamt   = {1'b0, rd_off_q, 3'b000};
    assign rotated = (line_q[head_q] >> shamt) |
                     (line_q[head_q] << ((OFF_W+4)'(LINE_W) - shamt));
    assign insn    = rotated[31:0];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            rd_off_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + PTR_W'(1);
            end
            if (pop) begin
                head_q <= head_nxt;
            end
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
            if (push && new_head) begin
                rd_off_q <= fill.addr[OFF_W-1:0];
            end else if (pop) begin
                rd_off_q <= start_q[head_nxt];   // Unused when the queue runs empty
            end else if (advance) begin
                rd_off_q <= rd_off_inc[OFF_W-1:0];
            end
        end
    end

    // Payload write at tail
    always_ff @(posedge clk) begin
        if (push) begin
            line_q[tail_q]  <= fill.line;
            start_q[tail_q] <= fill.addr[OFF_W-1:0];
        end
    end

endmodule

// File: hw/fetch_top.sv
module fetch_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  fetch_pkg::resteer_t    resteer,
    input  fetch_pkg::btb_update_t btb_update,
    input  fetch_pkg::fill_t       fill,
    output fetch_pkg::addr_t       fetch_pc,
    output logic                   fetch_req,
    output fetch_pkg::insn_t       insn,
    output logic                   insn_valid
);

    fetch_pkg::redirect_t pred;        // BTB lookup for the current PC
    logic                 ibuff_full;  // Back-pressure into the PC

    // PC and next-PC select
    fetch_pc u_pc (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .ibuff_full (ibuff_full),
        .resteer    (resteer),
        .pred       (pred),
        .pc         (fetch_pc),
        .req        (fetch_req)
    );

    // Direct-mapped predictor
    btb_predictor u_btb (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (fetch_pc),
        .update    (btb_update),
        .pred      (pred)
    );

    // Any resteer strobe drops buffered lines
    ibuff u_ibuff (
        .clk        (clk),
        .rst        (rst),
        .flush      (resteer.strobe),
        .stall      (stall),
        .fill       (fill),
        .insn       (insn),
        .insn_valid (insn_valid),
        .full       (ibuff_full)
    );

endmodule

// File: test/tb_clock.sv
module tb_clock #(
    parameter real PERIOD = 8.0    // ns
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #(PERIOD / 2.0) clk = ~clk;    // Free running

endmodule

// File: test/fetch_top_sva.sv
module fetch_top_sva (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic             resteer_strobe,
    input fetch_pkg::addr_t fetch_pc,
    input logic             fetch_req,
    input logic             insn_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Outputs quiet while reset is applied
    a_reset_quiet: assert property (@(posedge clk) rst |=> (!fetch_req && !insn_valid))
        else $error("fetch_req or insn_valid high after a reset cycle");

    // Resteer empties the buffer at the edge
    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        resteer_strobe |=> !insn_valid)
        else $error("insn_valid high in the cycle after a resteer");

    // Stall freezes the PC
    a_stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(fetch_pc))
        else $error("fetch_pc moved across a stalled cycle");

endmodule

bind fetch_top fetch_top_sva u_sva (
    .clk            (clk),
    .rst            (rst),
    .stall          (stall),
    .resteer_strobe (resteer.strobe),
    .fetch_pc       (fetch_pc),
    .fetch_req      (fetch_req),
    .insn_valid     (insn_valid)
);

// File: test/fetch_top_tb.sv
`include "fetch_cfg.svh"

module fetch_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int A_IDLE = 0, A_RS = 1, A_UPD = 2, A_FILL = 3;          // Step actions
    localparam int C_PC = 1, C_HOLD = 2, C_INSN = 3, C_REQ = 4, C_VALID = 5;

    // One table row
    // tk is {rob, dec, ras} for a resteer and tk[0] the taken bit for an update
    typedef struct packed {
        logic [1:0]       act;
        logic             stall;
        logic [2:0]       tk;
        fetch_pkg::addr_t a;       // Rob target, branch pc or fill address
        fetch_pkg::addr_t b;       // Dec target or branch target
        fetch_pkg::addr_t c;       // Ras target
        logic [4:0]       wait_n;  // Extra idle cycles before the check
        logic [2:0]       chk;
        logic [3:0]       chk_id;  // Fill number for insn checks
        fetch_pkg::addr_t exp;     // PC, byte offset or level
    } step_t;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    fetch_pkg::resteer_t    resteer;
    fetch_pkg::btb_update_t btb_update;
    fetch_pkg::fill_t       fill;
    fetch_pkg::addr_t       fetch_pc;
    logic                   fetch_req;
    fetch_pkg::insn_t       insn;
    logic                   insn_valid;

    int               seed;
    logic [7:0]       seed_byte [16];   // One per fill
    int               fill_count;
    fetch_pkg::addr_t last_pc;          // PC seen at the previous check
    step_t            step_q [$];
    string            name_q [$];

    tb_clock #(.PERIOD(8.0)) u_clk (.clk(clk));

    fetch_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resteer    (resteer),
        .btb_update (btb_update),
        .fill       (fill),
        .fetch_pc   (fetch_pc),
        .fetch_req  (fetch_req),
        .insn       (insn),
        .insn_valid (insn_valid)
    );

    task automatic add_step(input string name, input int act, input int st,
                            input logic [2:0] tk, input fetch_pkg::addr_t a,
                            input fetch_pkg::addr_t b, input fetch_pkg::addr_t c,
                            input int wn, input int chk, input int cid,
                            input fetch_pkg::addr_t exp);
        step_t s;
        s = '{act: 2'(act), stall: 1'(st), tk: tk, a: a, b: b, c: c, wait_n: 5'(wn),
              chk: 3'(chk), chk_id: 4'(cid), exp: exp};
        step_q.push_back(s);
        name_q.push_back(name);
    endtask

    // Byte k of a fill line holds k plus the fill's seed byte
    function automatic fetch_pkg::line_t build_line(input int id);
        fetch_pkg::line_t l;
        for (int k = 0; k < `FETCH_LINE_BYTES; k++) begin
            l[k*8 +: 8] = 8'(k) + seed_byte[id];
        end
        return l;
    endfunction

    // Word starting at byte off and wrapping inside the line
    function automatic fetch_pkg::insn_t expect_word(input int id, input int off);
        fetch_pkg::insn_t w;
        for (int j = 0; j < 4; j++) begin
            w[j*8 +: 8] = 8'((off + j) % `FETCH_LINE_BYTES) + seed_byte[id];
        end
        return w;
    endfunction

    task automatic drive_step(input step_t s);
        fetch_pkg::resteer_t    rs;
        fetch_pkg::btb_update_t up;
        fetch_pkg::fill_t       fl;
        rs = '0;
        up = '0;
        fl = '0;
        case (s.act)
            2'(A_RS): begin
                rs.strobe     = 1'b1;
                rs.rob.taken  = s.tk[2];
                rs.rob.target = s.a;
                rs.dec.taken  = s.tk[1];
                rs.dec.target = s.b;
                rs.ras.taken  = s.tk[0];
                rs.ras.target = s.c;
            end
            2'(A_UPD): up = '{strobe: 1'b1, pc: s.a, target: s.b, taken: s.tk[0]};
            2'(A_FILL): begin
                fl = '{strobe: 1'b1, addr: s.a, line: build_line(fill_count)};
                fill_count++;                      // Fills numbered in table order
            end
            default: ;
        endcase
        stall      <= s.stall;
        resteer    <= rs;
        btb_update <= up;
        fill       <= fl;
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t exp,
                              input fetch_pkg::addr_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Address mismatch");
        end
    endtask

    task automatic check_insn(input string name, input fetch_pkg::insn_t exp,
                              input fetch_pkg::insn_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Instruction mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Level mismatch");
        end
    endtask

    task automatic run_check(input string name, input step_t s);
        case (s.chk)
            3'(C_PC):   check_addr(name, s.exp, fetch_pc);
            3'(C_HOLD): check_addr(name, last_pc, fetch_pc);
            3'(C_INSN): begin
                check_level(name, 1'b1, insn_valid);
                check_insn(name, expect_word(int'(s.chk_id), int'(s.exp[5:0])), insn);
            end
            3'(C_REQ):   check_level(name, s.exp[0], fetch_req);
            3'(C_VALID): check_level(name, s.exp[0], insn_valid);
            default: ;
        endcase
    endtask

    // Each row expects the effect of the rows before it
    task automatic build_table();
        add_step("seq_reset",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h0);
        add_step("seq_step",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h40);
        add_step("stall_on",   A_IDLE, 1, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h80);
        add_step("stall_hold", A_IDLE, 1, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h80);
        add_step("stall_off",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h80);
        add_step("rs_rob",     A_RS, 0, 3'b110, 'h1000, 'h2000, 0, 0, C_PC, 0, 'hc0);
        add_step("rs_dec",     A_RS, 0, 3'b011, 0, 'h3000, 'h4000, 0, C_PC, 0, 'h1000);
        add_step("rs_ras",     A_RS, 0, 3'b001, 0, 0, 'h5008, 0, C_PC, 0, 'h3000);
        add_step("ras_land",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h5008);
        add_step("train_1",    A_UPD, 0, 3'b001, 'h5100, 'h8000, 0, 0, C_PC, 0, 'h5040);
        add_step("train_2",    A_UPD, 0, 3'b001, 'h5100, 'h8000, 0, 0, C_PC, 0, 'h5080);
        add_step("pre_line",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h50c0);
        add_step("br_line",    A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h5100);
        add_step("pred_hit",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h8000);
        add_step("untrain",    A_UPD, 0, 3'b000, 'h5100, 'h8000, 0, 0, C_PC, 0, 'h8040);
        add_step("back_rs",    A_RS, 0, 3'b001, 0, 0, 'h5100, 0, C_PC, 0, 'h8080);
        add_step("br_again",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h5100);
        add_step("pred_miss",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h5140);
        add_step("fill_a",     A_FILL, 0, 3'b000, 'h6008, 0, 0, 0, C_PC, 0, 'h5180);
        add_step("fill_b",     A_FILL, 0, 3'b000, 'h6044, 0, 0, 0, C_INSN, 0, 8);
        add_step("word_12",    A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_INSN, 0, 12);
        add_step("word_16",    A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_INSN, 0, 16);
        add_step("word_60",    A_IDLE, 0, 3'b000, 0, 0, 0, 10, C_INSN, 0, 60);
        add_step("next_line",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_INSN, 1, 4);
        add_step("insn_stall", A_IDLE, 1, 3'b000, 0, 0, 0, 0, C_INSN, 1, 8);
        add_step("insn_held",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_INSN, 1, 8);
        add_step("insn_move",  A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_INSN, 1, 12);
        add_step("fill_c",     A_FILL, 1, 3'b000, 'h7000, 0, 0, 0, C_INSN, 1, 16);
        add_step("fill_d",     A_FILL, 1, 3'b000, 'h7010, 0, 0, 0, C_INSN, 1, 16);
        add_step("fill_e",     A_FILL, 1, 3'b000, 'h7020, 0, 0, 0, C_INSN, 1, 16);
        add_step("full_req",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_REQ, 0, 'h0);
        add_step("full_hold",  A_RS, 1, 3'b100, 'h9000, 0, 0, 0, C_HOLD, 0, 'h0);
        add_step("flushed",    A_RS, 0, 3'b100, 'h9000, 0, 0, 0, C_VALID, 0, 'h0);
        add_step("rs_land",    A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h9000);
        add_step("rs_step",    A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_PC, 0, 'h9040);
        add_step("req_high",   A_IDLE, 0, 3'b000, 0, 0, 0, 0, C_REQ, 0, 'h1);
    endtask

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        resteer    = '0;
        btb_update = '0;
        fill       = '0;
        fill_count = 0;
        last_pc    = '0;
        seed       = 32'h29467685;
        for (int i = 0; i < 16; i++) begin
            seed_byte[i] = 8'($random(seed));
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < step_q.size(); i++) begin
            @(posedge clk);
            drive_step(step_q[i]);
            repeat (int'(step_q[i].wait_n)) begin
                @(posedge clk);
                drive_step('0);                  // Plain idle cycles
            end
            @(negedge clk);                      // Outputs settled
            run_check(name_q[i], step_q[i]);
            last_pc = fetch_pc;
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog allows 20 cycles per row on top of reset
    initial begin
        #1;
        repeat (RESET_CYCLES + 20 * step_q.size()) @(posedge clk);
        $display("Watchdog expired, the run hung");
        $display("STATUS: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

// File: fetch_top.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_pc.sv
hw/btb_predictor.sv
hw/ibuff.sv
hw/fetch_top.sv
test/tb_clock.sv
test/fetch_top_sva.sv
test/fetch_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module fetch_top_tb -f fetch_top.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vfetch_top_tb > sim.log 2>&1 || echo "Simulator returned an error" >> sim.log
cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log || exit 1
